/* mipsPkg.sv */
package mipsPkg;

    typedef logic [4:0] regAddr;

    // register-format view
    typedef struct packed {
        logic [5:0] opcode;
        regAddr     rs;
        regAddr     rt;
        regAddr     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // immediate-format view
    typedef struct packed {
        logic [5:0]  opcode;
        regAddr      rs;
        regAddr      rt;
        logic [15:0] imm16;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOp;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic aluSrcImm;
        aluOp aluCtl;
    } ctrlBits;

    typedef struct packed {
        logic        valid;
        ctrlBits     ctrl;
        logic [31:0] pc;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        regAddr      rs;
        regAddr      rt;
        regAddr      destReg;
    } idExReg;

    typedef struct packed {
        logic        valid;
        ctrlBits     ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        regAddr      destReg;
    } exMemReg;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        regAddr      destReg;
        logic [31:0] wbData;
    } memWbReg;

endpackage

/* hazardUnit.sv */
module hazardUnit (
    input  mipsPkg::regAddr ifIdRs,
    input  mipsPkg::regAddr ifIdRt,
    input  mipsPkg::regAddr idExDest,
    input  mipsPkg::regAddr exMemDest,
    input  logic            idExRegWrite,
    input  logic            exMemRegWrite,
    output logic            stall
);

    logic idExHit;
    logic exMemHit;

    // no forwarding, so any pending write to a source must drain first
    always_comb begin
        idExHit = 1'b0;
        exMemHit = 1'b0;

        if (idExRegWrite && (idExDest != '0)) begin
            if ((idExDest == ifIdRs) || (idExDest == ifIdRt)) begin
                idExHit = 1'b1;
            end
        end

        if (exMemRegWrite && (exMemDest != '0)) begin
            if ((exMemDest == ifIdRs) || (exMemDest == ifIdRt)) begin
                exMemHit = 1'b1;
            end
        end
    end

    assign stall = idExHit || exMemHit; // writeback is covered by regFile bypass

endmodule

/* fetchUnit.sv */
module fetchUnit #(
    parameter int imemDepth = 256
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         run,
    input  logic                         hold,
    input  logic                         redirect,
    input  logic [31:0]                  redirectPc,
    input  logic                         imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [31:0]                  imemData,
    output logic [31:0]                  pc,
    output mipsPkg::instrWord            instr
);

    localparam int addrBits = $clog2(imemDepth);

    logic [31:0] imem [imemDepth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            if (redirect) begin
                pc <= redirectPc; // taken branch beats hold
            end else if (!hold) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // program load only while the core is parked
    always_ff @(posedge clk) begin
        if (imemWe && !run) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr = imem[pc[addrBits+1:2]];

endmodule

/* decodeUnit.sv */
module decodeUnit (
    input  mipsPkg::instrWord instr,
    output mipsPkg::ctrlBits  ctrl,
    output mipsPkg::regAddr   rs,
    output mipsPkg::regAddr   rt,
    output mipsPkg::regAddr   destReg,
    output logic [31:0]       imm
);
    import mipsPkg::*;

    assign rs = instr.i.rs;
    assign rt = instr.i.rt;
    assign imm = {{16{instr.i.imm16[15]}}, instr.i.imm16};

    always_comb begin
        ctrl = '0;
        destReg = '0;

        case (instr.r.opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                destReg = instr.r.rd;
                case (instr.r.funct)
                    fnAdd: ctrl.aluCtl = aluAdd;
                    fnSub: ctrl.aluCtl = aluSub;
                    fnAnd: ctrl.aluCtl = aluAnd;
                    fnOr:  ctrl.aluCtl = aluOr;
                    fnSlt: ctrl.aluCtl = aluSlt;
                    default: begin
                        ctrl.regWrite = 1'b0; // unsupported funct acts as nop
                        destReg = '0;
                    end
                endcase
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtl = aluAdd;
                destReg = instr.i.rt;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtl = aluAdd;
                destReg = instr.i.rt;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtl = aluAdd; // address = rs + imm
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluCtl = aluSub;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* regFile.sv */
module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  mipsPkg::regAddr rdAddrA,
    input  mipsPkg::regAddr rdAddrB,
    input  logic            wrEn,
    input  mipsPkg::regAddr wrAddr,
    input  logic [31:0]     wrData,
    output logic [31:0]     rdDataA,
    output logic [31:0]     rdDataB
);

    logic [31:0] regs [32];
    logic        hitA;
    logic        hitB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write shows up on the read side
    assign hitA = wrEn && (wrAddr == rdAddrA);
    assign hitB = wrEn && (wrAddr == rdAddrB);

    assign rdDataA = (rdAddrA == '0) ? '0 : (hitA ? wrData : regs[rdAddrA]);
    assign rdDataB = (rdAddrB == '0) ? '0 : (hitB ? wrData : regs[rdAddrB]);

endmodule

/* executeUnit.sv */
module executeUnit (
    input  mipsPkg::idExReg stage,
    output logic [31:0]     aluResult,
    output logic [31:0]     storeData,
    output logic [31:0]     branchTarget,
    output logic            branchTaken
);
    import mipsPkg::*;

    logic [31:0] opA;
    logic [31:0] opB;

    assign opA = stage.rsVal;
    assign opB = stage.ctrl.aluSrcImm ? stage.imm : stage.rtVal;

    always_comb begin
        case (stage.ctrl.aluCtl)
            aluAdd: aluResult = opA + opB;
            aluSub: aluResult = opA - opB;
            aluAnd: aluResult = opA & opB;
            aluOr:  aluResult = opA | opB;
            aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    assign storeData = stage.rtVal;

    // beq compares the raw register values
    assign branchTaken = stage.valid && stage.ctrl.branch && (stage.rsVal == stage.rtVal);
    assign branchTarget = stage.pc + 32'd4 + {stage.imm[29:0], 2'b00};

endmodule

/* dataMem.sv */
module dataMem #(
    parameter int dmemDepth = 256
) (
    input  logic                         clk,
    input  logic                         wrEn,
    input  logic [$clog2(dmemDepth)-1:0] addr,
    input  logic [31:0]                  wrData,
    output logic [31:0]                  rdData
);

    logic [31:0] mem [dmemDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = mem[addr]; // async read, value ready within the memory stage

endmodule

/* pipeCore.sv */
module pipeCore #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         run,
    input  logic                         imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [31:0]                  imemData,
    output logic                         wbValid,
    output mipsPkg::regAddr              wbReg,
    output logic [31:0]                  wbData
);
    import mipsPkg::*;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrWord    instr;
    } ifIdReg;

    localparam int dAddrBits = $clog2(dmemDepth);

    ifIdReg  ifId;
    idExReg  idEx;
    idExReg  idExNext;
    exMemReg exMem;
    exMemReg exMemNext;
    memWbReg memWb;
    memWbReg memWbNext;

    logic [31:0] fetchPc;
    instrWord    fetchInstr;
    logic        stall;
    logic        branchTaken;
    logic [31:0] branchTarget;

    ctrlBits     decCtrl;
    regAddr      decRs;
    regAddr      decRt;
    regAddr      decDest;
    logic [31:0] decImm;
    logic [31:0] rsVal;
    logic [31:0] rtVal;

    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [31:0] memRdData;

    fetchUnit #(.imemDepth(imemDepth)) fetch0 (
        .clk(clk), .arstN(arstN), .run(run),
        .hold(stall), .redirect(branchTaken), .redirectPc(branchTarget),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .pc(fetchPc), .instr(fetchInstr)
    );

    decodeUnit decode0 (
        .instr(ifId.instr), .ctrl(decCtrl),
        .rs(decRs), .rt(decRt), .destReg(decDest), .imm(decImm)
    );

    regFile regs0 (
        .clk(clk), .arstN(arstN),
        .rdAddrA(decRs), .rdAddrB(decRt),
        .wrEn(memWb.valid && memWb.regWrite),
        .wrAddr(memWb.destReg), .wrData(memWb.wbData),
        .rdDataA(rsVal), .rdDataB(rtVal)
    );

    hazardUnit hazard0 (
        .ifIdRs(decRs), .ifIdRt(decRt),
        .idExDest(idEx.destReg), .exMemDest(exMem.destReg),
        .idExRegWrite(idEx.valid && idEx.ctrl.regWrite),
        .exMemRegWrite(exMem.valid && exMem.ctrl.regWrite),
        .stall(stall)
    );

    executeUnit execute0 (
        .stage(idEx), .aluResult(aluResult), .storeData(storeData),
        .branchTarget(branchTarget), .branchTaken(branchTaken)
    );

    dataMem #(.dmemDepth(dmemDepth)) dmem0 (
        .clk(clk),
        .wrEn(exMem.valid && exMem.ctrl.memWrite),
        .addr(exMem.aluResult[dAddrBits+1:2]), // byte address to word index
        .wrData(exMem.storeData),
        .rdData(memRdData)
    );

    always_comb begin
        idExNext.valid = ifId.valid;
        idExNext.ctrl = ifId.valid ? decCtrl : '0;
        idExNext.pc = ifId.pc;
        idExNext.rsVal = rsVal;
        idExNext.rtVal = rtVal;
        idExNext.imm = decImm;
        idExNext.rs = decRs;
        idExNext.rt = decRt;
        idExNext.destReg = decDest;

        exMemNext.valid = idEx.valid;
        exMemNext.ctrl = idEx.ctrl;
        exMemNext.aluResult = aluResult;
        exMemNext.storeData = storeData;
        exMemNext.destReg = idEx.destReg;

        memWbNext.valid = exMem.valid;
        memWbNext.regWrite = exMem.ctrl.regWrite;
        memWbNext.destReg = exMem.destReg;
        memWbNext.wbData = exMem.ctrl.memRead ? memRdData : exMem.aluResult;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
        end else if (!run) begin
            ifId <= '0; // parked, pipeline stays empty
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
        end else begin
            if (branchTaken) begin
                ifId <= '0;
            end else if (!stall) begin
                ifId.valid <= 1'b1;
                ifId.pc <= fetchPc;
                ifId.instr <= fetchInstr;
            end

            // bubble on stall or flush
            idEx <= (branchTaken || stall) ? '0 : idExNext;
            exMem <= exMemNext;
            memWb <= memWbNext;
        end
    end

    assign wbValid = memWb.valid && memWb.regWrite && (memWb.destReg != '0);
    assign wbReg = memWb.destReg;
    assign wbData = memWb.wbData;

endmodule

/* tbIsaModel.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// architectural model, one instruction per step, no pipeline timing
function automatic void runIsaModel();
    logic [31:0] regs [32];
    logic [31:0] mem [dmemDepth];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] addr;
    instrWord    w;
    regAddr      dest;
    logic        writes;
    int          steps;
    int          idx;
    int          k;
    bit          parked;

    for (k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (k = 0; k < dmemDepth; k++) begin
        mem[k] = '0;
    end
    pc = '0;
    steps = 0;
    parked = 1'b0;

    while (!parked) begin
        if (steps >= maxModelSteps) begin
            $display("Verification failed");
            $fatal(1, "reference model never reached the closing branch loop");
        end
        idx = int'(pc[31:2]);
        w = (idx < prog.size()) ? prog[idx] : '0; // past the end acts as a nop
        imm = {{16{w.i.imm16[15]}}, w.i.imm16};
        opA = regs[w.i.rs];
        opB = regs[w.i.rt];
        addr = opA + imm;
        nextPc = pc + 32'd4;
        dest = '0;
        writes = 1'b0;
        res = '0;

        case (w.i.opcode)
            opRType: begin
                dest = w.r.rd;
                writes = 1'b1;
                case (w.r.funct)
                    fnAdd: res = opA + opB;
                    fnSub: res = opA - opB;
                    fnAnd: res = opA & opB;
                    fnOr:  res = opA | opB;
                    fnSlt: res = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            opAddi: begin
                dest = w.i.rt;
                writes = 1'b1;
                res = addr;
            end
            opLw: begin
                dest = w.i.rt;
                writes = 1'b1;
                res = mem[addr[dAddrBits+1:2]];
            end
            opSw: mem[addr[dAddrBits+1:2]] = opB;
            opBeq: begin
                if (opA == opB) begin
                    nextPc = pc + 32'd4 + (imm << 2);
                    parked = (nextPc == pc); // self loop ends the program
                end
            end
            default: ;
        endcase

        if (writes && (dest != '0)) begin
            regs[dest] = res;
            expQ.push_back(wbEntry'{rd: dest, val: res});
        end
        pc = nextPc;
        steps++;
    end
endfunction

`endif

/* pipeCoreTb.sv */
module pipeCoreTb;
    import mipsPkg::*;

    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int iAddrBits = $clog2(imemDepth);
    localparam int dAddrBits = $clog2(dmemDepth);
    localparam int clkPeriod = 40;
    localparam int prologLen = 8;
    localparam int mixLen = 60;
    localparam int maxProgLen = prologLen + mixLen + 1;
    localparam int numPrograms = 6;
    localparam int drainCycles = 20;
    localparam int maxModelSteps = 4096;
    localparam int watchdogCycles = numPrograms * (maxProgLen * 20 + imemDepth + drainCycles + 8);

    typedef struct packed {
        regAddr      rd;
        logic [31:0] val;
    } wbEntry;

    logic                 clk;
    logic                 arstN;
    logic                 run;
    logic                 imemWe;
    logic [iAddrBits-1:0] imemAddr;
    logic [31:0]          imemData;
    logic                 wbValid;
    regAddr               wbReg;
    logic [31:0]          wbData;

    logic [31:0] prog [$];
    wbEntry      expQ [$];
    wbEntry      nextExp;

    `include "tbIsaModel.svh"

    pipeCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) dut0 (
        .clk(clk), .arstN(arstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Verification failed");
        $fatal(1, "timeout, the core stopped producing the expected writebacks");
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] rType(input logic [5:0] fn, input regAddr rd,
                                          input regAddr rs, input regAddr rt);
        instrWord w;
        w.r = '{opcode: opRType, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: fn};
        return w;
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input regAddr rs,
                                          input regAddr rt, input logic [15:0] imm);
        instrWord w;
        w.i = '{opcode: op, rs: rs, rt: rt, imm16: imm};
        return w;
    endfunction

    // nop with the word address in the rd and shamt bits
    function automatic logic [31:0] fillWord(input int a);
        return {16'h0000, 10'(a), 6'h00};
    endfunction

    function automatic logic [31:0] randomAlu(input regAddr rd, input regAddr rs, input regAddr rt);
        int pick;
        pick = $urandom_range(0, 5);
        case (pick)
            0: return rType(fnAdd, rd, rs, rt);
            1: return rType(fnSub, rd, rs, rt);
            2: return rType(fnAnd, rd, rs, rt);
            3: return rType(fnOr, rd, rs, rt);
            4: return rType(fnSlt, rd, rs, rt);
            default: return iType(opAddi, rs, rd, 16'($urandom));
        endcase
    endfunction

    // clear the data words the programs touch
    task automatic startProgram();
        int k;
        prog.delete();
        for (k = 0; k < prologLen; k++) begin
            prog.push_back(iType(opSw, 5'd0, 5'd0, 16'(4 * k)));
        end
    endtask

    task automatic runProgram(input string title);
        int a;
        prog.push_back(iType(opBeq, 5'd0, 5'd0, 16'hffff)); // park on a self loop
        expQ.delete();
        runIsaModel();
        $display("%s: %0d words, %0d writebacks", title, prog.size(), expQ.size());

        @(posedge clk);
        #5;
        run = 1'b0;
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        arstN = 1'b1;
        for (a = 0; a < imemDepth; a++) begin
            imemWe = 1'b1;
            imemAddr = a[iAddrBits-1:0];
            imemData = (a < prog.size()) ? prog[a] : fillWord(a);
            @(posedge clk);
            #5;
        end
        imemWe = 1'b0;
        run = 1'b1;

        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (drainCycles) @(posedge clk); // extra writebacks show up here
        #5;
        run = 1'b0;
    endtask

    // one expected write popped per writeback strobe
    always @(negedge clk) begin
        if (arstN && wbValid) begin
            if (expQ.size() == 0) begin
                $display("Verification failed");
                $fatal(1, "write to register %0d arrived that the model never made", wbReg);
            end else begin
                nextExp = expQ.pop_front();
                checkValue("wbReg", 32'(wbReg), 32'(nextExp.rd));
                checkValue("wbData", wbData, nextExp.val);
            end
        end
    end

    initial begin
        int i;
        int off;
        int pick;
        regAddr d;
        regAddr s;
        regAddr t;

        arstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(75));

        startProgram();
        for (i = 1; i <= 8; i++) begin
            prog.push_back(iType(opAddi, 5'd0, 5'(i), 16'($urandom)));
        end
        for (i = 0; i < 16; i++) begin
            prog.push_back(randomAlu(5'($urandom_range(9, 31)), 5'($urandom_range(1, 8)),
                                     5'($urandom_range(1, 8))));
        end
        runProgram("independent alu");

        startProgram();
        prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'($urandom)));
        prog.push_back(iType(opAddi, 5'd1, 5'd2, 16'($urandom))); // distance one
        prog.push_back(rType(fnAdd, 5'd3, 5'd2, 5'd1));
        prog.push_back(iType(opAddi, 5'd0, 5'd9, 16'd1));
        prog.push_back(rType(fnSub, 5'd4, 5'd3, 5'd9)); // r3 at distance two
        prog.push_back(rType(fnOr, 5'd5, 5'd4, 5'd2));
        prog.push_back(rType(fnSlt, 5'd6, 5'd5, 5'd4));
        prog.push_back(iType(opAddi, 5'd6, 5'd6, 16'($urandom)));
        runProgram("dependent chains");

        startProgram();
        prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'($urandom)));
        prog.push_back(iType(opSw, 5'd0, 5'd1, 16'd8));
        prog.push_back(iType(opLw, 5'd0, 5'd2, 16'd8));
        prog.push_back(rType(fnAdd, 5'd3, 5'd2, 5'd2)); // load use
        prog.push_back(iType(opLw, 5'd0, 5'd4, 16'd12));
        prog.push_back(rType(fnAdd, 5'd5, 5'd4, 5'd1));
        prog.push_back(iType(opAddi, 5'd0, 5'd7, 16'd20));
        prog.push_back(iType(opSw, 5'd7, 5'd3, 16'd4));
        prog.push_back(iType(opLw, 5'd0, 5'd6, 16'd24));
        runProgram("load store");

        startProgram();
        prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd3));
        prog.push_back(iType(opAddi, 5'd0, 5'd2, 16'd3));
        prog.push_back(iType(opBeq, 5'd1, 5'd2, 16'd2)); // taken
        prog.push_back(iType(opAddi, 5'd0, 5'd3, 16'd11));
        prog.push_back(iType(opAddi, 5'd0, 5'd4, 16'd22));
        prog.push_back(iType(opAddi, 5'd0, 5'd5, 16'd33));
        prog.push_back(iType(opBeq, 5'd1, 5'd5, 16'd2)); // not taken
        prog.push_back(iType(opAddi, 5'd0, 5'd6, 16'd44));
        prog.push_back(iType(opAddi, 5'd0, 5'd7, 16'd55));
        runProgram("branches");

        startProgram();
        prog.push_back(iType(opAddi, 5'd0, 5'd0, 16'd99));
        prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd5));
        prog.push_back(rType(fnAdd, 5'd0, 5'd1, 5'd1));
        prog.push_back(iType(opAddi, 5'd0, 5'd2, 16'd0));
        prog.push_back(rType(fnSub, 5'd3, 5'd0, 5'd1));
        prog.push_back(rType(fnOr, 5'd4, 5'd0, 5'd0));
        runProgram("register zero");

        startProgram();
        for (i = 0; i < mixLen; i++) begin
            pick = $urandom_range(0, 6);
            d = 5'($urandom_range(0, 7));
            s = 5'($urandom_range(0, 7));
            t = 5'($urandom_range(0, 7));
            if (pick < 4) begin
                prog.push_back(randomAlu(d, s, t));
            end else if (pick == 4) begin
                prog.push_back(iType(opLw, 5'd0, d, 16'(4 * $urandom_range(0, 7))));
            end else if (pick == 5) begin
                prog.push_back(iType(opSw, 5'd0, t, 16'(4 * $urandom_range(0, 7))));
            end else begin
                off = (mixLen - 1 - i < 3) ? mixLen - 1 - i : 3; // stay inside the program
                prog.push_back(iType(opBeq, s & 5'd3, t & 5'd3, 16'($urandom_range(0, off))));
            end
        end
        runProgram("random mix");

        $display("Verification passed");
        $finish;
    end

endmodule

/* pipeCore.f */
+incdir+.
mipsPkg.sv
hazardUnit.sv
fetchUnit.sv
decodeUnit.sv
regFile.sv
executeUnit.sv
dataMem.sv
pipeCore.sv
pipeCoreTb.sv

/* runSim.sh */
#!/bin/sh
# compile and run the pipeCore testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --top-module pipeCoreTb -f pipeCore.f -o pipeCoreSim
./obj_dir/pipeCoreSim
